// File: clint.f
design/clint_pkg.sv
design/clint_addr_decode.sv
design/clint_timer_regs.sv
design/clint_read_resp.sv
design/clint_top.sv
testbench/tb_clk_gen.sv
testbench/tb_clint.sv

// File: design/clint_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module clint_addr_decode (
	input  logic                         clk,
	input  logic                         rst,
	// write address and write data channels
	input  logic [clint_pkg::ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [clint_pkg::DATA_W-1:0] wdata,
	input  logic                         wvalid,
	output logic                         wready,
	// read address channel
	input  logic [clint_pkg::ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	// pending responses from the result block
	input  logic                         b_busy,
	input  logic                         r_busy,
	// strobes towards the timer registers and result block
	output logic                         wr_en,
	output clint_pkg::reg_sel_e          wr_sel,
	output logic [clint_pkg::DATA_W-1:0] wr_data,
	output logic                         wr_done,
	output logic                         rd_en,
	output clint_pkg::reg_sel_e          rd_sel
);
	import clint_pkg::*;

	logic aw_go;   // accept a write on the next cycle
	logic wr_fire; // write transfer on this edge
	logic ar_go;   // accept a read on the next cycle
	logic rd_fire; // read transfer on this edge

	// offset -> register, exact match only
	function automatic reg_sel_e map_ofs(input logic [ADDR_W-1:0] ofs);
		reg_sel_e sel;
		case (ofs)
			MSIP_OFS:     sel = SEL_MSIP;
			MTIMECMP_OFS: sel = SEL_MTIMECMP;
			MTIME_OFS:    sel = SEL_MTIME;
			default:      sel = SEL_NONE; // anything else is a hole
		endcase
		return sel;
	endfunction

	// a write needs address and data together; hold off while one is in flight
	// wr_done covers the gap before bvalid shows up as b_busy
	assign aw_go   = awvalid && wvalid && !awready && !wr_done && !b_busy;
	assign wr_fire = awvalid && awready && wvalid && wready;

	// same idea for reads, rd_en covers the gap before rvalid
	assign ar_go   = arvalid && !arready && !rd_en && !r_busy;
	assign rd_fire = arvalid && arready;

	// write ready pulses, one cycle wide, both channels together
	always_ff @(posedge clk) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
		end else begin
			awready <= aw_go; // drops again after the transfer cycle
			wready  <= aw_go;
		end
	end

	// read ready pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
		end else begin
			arready <= ar_go;
		end
	end

	// write strobes, one cycle after the transfer
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en   <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			wr_en   <= wr_fire && (map_ofs(awaddr) != SEL_NONE); // holes touch nothing
			wr_done <= wr_fire; // every write gets a response
		end
	end

	// captured write payload
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			wr_sel  <= map_ofs(awaddr);
			wr_data <= wdata;
		end
	end

	// read strobe and its target
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_en <= 1'b0;
		end else begin
			rd_en <= rd_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rd_sel <= map_ofs(araddr); // held until the next read
		end
	end

endmodule : clint_addr_decode

`default_nettype wire

// File: design/clint_pkg.sv
`default_nettype none

package clint_pkg;

	// bus geometry
	parameter int ADDR_W = 16; // byte offset inside the clint window
	parameter int DATA_W = 64; // bus data and every timer register

	// register map, single hart
	parameter logic [ADDR_W-1:0] MSIP_OFS     = 16'h0000;
	parameter logic [ADDR_W-1:0] MTIMECMP_OFS = 16'h4000; // hart 0 compare
	parameter logic [ADDR_W-1:0] MTIME_OFS    = 16'hBFF8; // free-running counter

	// mtimecmp starts at the top so no timer irq fires out of reset
	parameter logic [DATA_W-1:0] MTIMECMP_RST = {DATA_W{1'b1}};

	// which register a bus access hits
	typedef enum logic [1:0] {
		SEL_NONE     = 2'd0, // unmapped offset
		SEL_MSIP     = 2'd1,
		SEL_MTIMECMP = 2'd2,
		SEL_MTIME    = 2'd3
	} reg_sel_e;

endpackage : clint_pkg

`default_nettype wire

// File: design/clint_read_resp.sv
`timescale 1ns/1ps
`default_nettype none

module clint_read_resp (
	input  logic                         clk,
	input  logic                         rst,
	// strobes from decode
	input  logic                         rd_en,
	input  clint_pkg::reg_sel_e          rd_sel,
	input  logic                         wr_done,
	// register contents
	input  logic [clint_pkg::DATA_W-1:0] mtime,
	input  logic [clint_pkg::DATA_W-1:0] mtimecmp,
	input  logic                         msip_bit,
	// read data and write response channels
	output logic [clint_pkg::DATA_W-1:0] rdata,
	output logic                         rvalid,
	output logic                         bvalid,
	input  logic                         rready,
	input  logic                         bready,
	// pending levels back to decode
	output logic                         r_busy,
	output logic                         b_busy
);
	import clint_pkg::*;

	logic [DATA_W-1:0] rd_mux; // value of the addressed register

	// read mux, holes read as zero
	always_comb begin
		case (rd_sel)
			SEL_MSIP:     rd_mux = {{(DATA_W-1){1'b0}}, msip_bit}; // zero-extended
			SEL_MTIMECMP: rd_mux = mtimecmp;
			SEL_MTIME:    rd_mux = mtime;
			default:      rd_mux = '0;
		endcase
	end

	// rdata is sampled once per read and then held
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= rd_mux;
		end
	end

	// rvalid up with the data, down when the master takes it
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_en) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0; // handshake done
		end
	end

	// write response, always OKAY so only the valid travels
	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
		end else if (wr_done) begin
			bvalid <= 1'b1; // same edge the register updates
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// decode stalls on these
	assign r_busy = rvalid;
	assign b_busy = bvalid;

endmodule : clint_read_resp

`default_nettype wire

// File: design/clint_timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer_regs #(
	parameter int TICK_DIV = 1 // clk cycles per mtime increment, 1 or more
) (
	input  logic                         clk,
	input  logic                         rst,
	// write strobe from decode
	input  logic                         wr_en,
	input  clint_pkg::reg_sel_e          wr_sel,
	input  logic [clint_pkg::DATA_W-1:0] wr_data,
	// register contents, always visible
	output logic [clint_pkg::DATA_W-1:0] mtime,
	output logic [clint_pkg::DATA_W-1:0] mtimecmp,
	output logic                         msip_bit,
	// timer interrupt level
	output logic                         mtip
);
	import clint_pkg::*;

	// prescaler width, at least one bit even for TICK_DIV of 1
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] PRE_MAX = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] pre_cnt; // cycles since last tick
	logic             tick;    // mtime advances this cycle
	logic             wr_mtime;
	logic             wr_cmp;
	logic             wr_msip;

	// decode the write strobe once
	assign wr_mtime = wr_en && (wr_sel == SEL_MTIME);
	assign wr_cmp   = wr_en && (wr_sel == SEL_MTIMECMP);
	assign wr_msip  = wr_en && (wr_sel == SEL_MSIP);

	// tick on wrap, every cycle when TICK_DIV is 1
	assign tick = (pre_cnt == PRE_MAX);

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt <= '0;
		end else if (tick) begin
			pre_cnt <= '0; // wrap
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// mtime: a bus write wins over the increment
	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
		end else if (wr_mtime) begin
			mtime <= wr_data;
		end else if (tick) begin
			mtime <= mtime + 1'b1;
		end
	end

	// compare register
	always_ff @(posedge clk) begin
		if (rst) begin
			mtimecmp <= MTIMECMP_RST;
		end else if (wr_cmp) begin
			mtimecmp <= wr_data;
		end
	end

	// software interrupt, only bit 0 is implemented
	always_ff @(posedge clk) begin
		if (rst) begin
			msip_bit <= 1'b0;
		end else if (wr_msip) begin
			msip_bit <= wr_data[0];
		end
	end

	// timer irq, one cycle behind the compare
	always_ff @(posedge clk) begin
		if (rst) begin
			mtip <= 1'b0;
		end else begin
			mtip <= (mtime >= mtimecmp); // unsigned compare
		end
	end

endmodule : clint_timer_regs

`default_nettype wire

// File: design/clint_top.sv
`timescale 1ns/1ps
`default_nettype none

module clint_top #(
	parameter int TICK_DIV = 1 // clk cycles per mtime tick
) (
	input  logic                         clk,
	input  logic                         rst,
	// write address
	input  logic [clint_pkg::ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	// write data
	input  logic [clint_pkg::DATA_W-1:0] wdata,
	input  logic                         wvalid,
	output logic                         wready,
	// write response
	output logic                         bvalid,
	input  logic                         bready,
	// read address
	input  logic [clint_pkg::ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	// read data
	output logic [clint_pkg::DATA_W-1:0] rdata,
	output logic                         rvalid,
	input  logic                         rready,
	// interrupt levels to the hart
	output logic                         mtip,
	output logic                         msip
);
	import clint_pkg::*;

	logic              wr_en;    // register write strobe
	reg_sel_e          wr_sel;
	logic [DATA_W-1:0] wr_data;
	logic              wr_done;  // write accepted, respond
	logic              rd_en;    // read accepted, sample mux
	reg_sel_e          rd_sel;
	logic              b_busy;
	logic              r_busy;
	logic [DATA_W-1:0] mtime;
	logic [DATA_W-1:0] mtimecmp;

	// bus acceptance and address map
	clint_addr_decode clint_addr_decode_inst (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.b_busy  (b_busy),
		.r_busy  (r_busy),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.wr_done (wr_done),
		.rd_en   (rd_en),
		.rd_sel  (rd_sel)
	);

	// mtime, mtimecmp, msip and the timer irq
	clint_timer_regs #(
		.TICK_DIV (TICK_DIV)
	) clint_timer_regs_inst (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_data  (wr_data),
		.mtime    (mtime),
		.mtimecmp (mtimecmp),
		.msip_bit (msip), // software irq is the register bit itself
		.mtip     (mtip)
	);

	// read data and write responses
	clint_read_resp clint_read_resp_inst (
		.clk      (clk),
		.rst      (rst),
		.rd_en    (rd_en),
		.rd_sel   (rd_sel),
		.wr_done  (wr_done),
		.mtime    (mtime),
		.mtimecmp (mtimecmp),
		.msip_bit (msip),
		.rdata    (rdata),
		.rvalid   (rvalid),
		.bvalid   (bvalid),
		.rready   (rready),
		.bready   (bready),
		.r_busy   (r_busy),
		.b_busy   (b_busy)
	);

endmodule : clint_top

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the clint testbench with verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f clint.f --top-module tb_clint \
	--Mdir obj_dir -o tb_clint_sim

out=$(./obj_dir/tb_clint_sim)
echo "$out"

if grep -qx "Verification passed" <<< "$out"; then
	exit 0
fi
exit 1

// File: testbench/tb_clint.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clint;
	import clint_pkg::*;

	localparam int TMO = 100; // cycles allowed per wait
	localparam logic [DATA_W-1:0] CMP_MAX = '1; // mtimecmp out of reset, all ones

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic              wvalid;
	logic              wready;
	logic              bvalid;
	logic              bready;
	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [DATA_W-1:0] rdata;
	logic              rvalid;
	logic              rready;
	logic              mtip;
	logic              msip;

	logic [31:0] lfsr = 32'hf4b996d4;
	int          val_err = 0;   // wrong read values or levels
	int          proto_err = 0; // channel rule violations
	int          tmo_err = 0;
	int          cyc = 0;       // rising edges since time zero

	tb_clk_gen clk_gen_inst (
		.clk (clk),
		.rst (rst)
	);

	clint_top #(
		.TICK_DIV (1)
	) clint_top_inst (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready),
		.mtip    (mtip),
		.msip    (msip)
	);

	always @(posedge clk) cyc <= cyc + 1;

	// responses hold until the master takes them
	assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else begin
			proto_err++;
			$display("ERROR %0t: bvalid dropped before bready", $time);
		end
	assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
		else begin
			proto_err++;
			$display("ERROR %0t: rvalid dropped before rready", $time);
		end
	assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> $stable(rdata))
		else begin
			proto_err++;
			$display("ERROR %0t: rdata changed while rvalid waited", $time);
		end
	// one outstanding transfer per direction
	assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready && !wready)
		else begin
			proto_err++;
			$display("ERROR %0t: write accepted with bvalid pending", $time);
		end
	assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
		else begin
			proto_err++;
			$display("ERROR %0t: read accepted with rvalid pending", $time);
		end

	// galois lfsr, one step per bit taken, bits shifted in lsb first
	function automatic logic [DATA_W-1:0] rand_bits(input int n);
		logic [DATA_W-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[DATA_W-2:0], lfsr[0]};
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
		end
		return v;
	endfunction

	task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] got);
		assert (got == exp) else begin
			val_err++;
			$display("ERROR %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic drive_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1; // both channels together
		wvalid  = 1'b1;
	endtask

	// transfer, then stop once bvalid is up
	task automatic finish_write();
		int n;
		n = 0;
		while (!(awready && wready) && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!(awready && wready)) begin
			tmo_err++;
			$display("timeout: write address and data were never accepted");
		end
		@(negedge clk); // transfer edge is behind us
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!bvalid) begin
			tmo_err++;
			$display("timeout: no write response arrived");
		end
	endtask

	task automatic take_bresp();
		int dly;
		dly = int'(rand_bits(3)); // 0..7 cycles back-pressure
		repeat (dly) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic drive_read(input logic [ADDR_W-1:0] addr);
		araddr  = addr;
		arvalid = 1'b1;
	endtask

	task automatic finish_read(output logic [DATA_W-1:0] data);
		int n;
		n = 0;
		while (!arready && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!arready) begin
			tmo_err++;
			$display("timeout: read address was never accepted");
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!rvalid) begin
			tmo_err++;
			$display("timeout: no read data arrived");
		end
		data = rdata;
	endtask

	task automatic take_rresp();
		int dly;
		dly = int'(rand_bits(3));
		repeat (dly) @(negedge clk);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		drive_write(addr, data);
		finish_write();
		take_bresp();
	endtask

	task automatic do_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		drive_read(addr);
		finish_read(data);
		take_rresp();
	endtask

	initial begin
		logic [DATA_W-1:0] got;
		logic [DATA_W-1:0] t0;
		logic [DATA_W-1:0] d;
		int                c0;
		int                n;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		n = 0;
		while (rst && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			tmo_err++;
			$display("timeout: reset was never released");
		end
		@(negedge clk);

		// out of reset, no irqs and compare at the top
		check_val("mtip", 64'd0, 64'(mtip));
		check_val("msip", 64'd0, 64'(msip));
		do_read(MTIMECMP_OFS, got);
		check_val("rdata mtimecmp", CMP_MAX, got);

		for (int i = 0; i < 4; i++) begin
			d = rand_bits(64);
			do_write(MTIMECMP_OFS, d);
			do_read(MTIMECMP_OFS, got);
			check_val("rdata mtimecmp", d, got);
		end
		do_write(MTIMECMP_OFS, CMP_MAX);

		// msip level moves before the response is taken
		drive_write(MSIP_OFS, 64'd1);
		finish_write();
		check_val("msip", 64'd1, 64'(msip));
		take_bresp();
		do_read(MSIP_OFS, got);
		check_val("rdata msip", 64'd1, got);
		drive_write(MSIP_OFS, 64'd0);
		finish_write();
		check_val("msip", 64'd0, 64'(msip));
		take_bresp();
		do_read(MSIP_OFS, got);
		check_val("rdata msip", 64'd0, got);

		// counter runs, and a loaded value keeps counting from there
		do_read(MTIME_OFS, t0);
		do_read(MTIME_OFS, got);
		assert (got > t0) else begin
			val_err++;
			$display("ERROR %0t: mtime expected above %h got %h", $time, t0, got);
		end
		d = rand_bits(62); // headroom against wrap
		c0 = cyc;
		do_write(MTIME_OFS, d);
		do_read(MTIME_OFS, got);
		assert (got >= d && got < d + 64'(cyc - c0)) else begin
			val_err++;
			$display("ERROR %0t: mtime expected in [%h, %h) got %h", $time,
				d, d + 64'(cyc - c0), got);
		end

		// timer irq 40 ticks out
		do_read(MTIME_OFS, t0);
		do_write(MTIMECMP_OFS, t0 + 64'd40);
		check_val("mtip", 64'd0, 64'(mtip)); // too early yet
		n = 0;
		while (!mtip && n < TMO) begin
			@(negedge clk);
			n++;
		end
		if (!mtip) begin
			tmo_err++;
			$display("timeout: mtip never rose after mtime reached mtimecmp");
		end
		do_write(MTIMECMP_OFS, CMP_MAX);
		check_val("mtip", 64'd0, 64'(mtip));

		// holes read zero and swallow writes
		do_read(16'h0008, got);
		check_val("rdata hole 0008", 64'd0, got);
		do_read(16'hBFFC, got);
		check_val("rdata hole bffc", 64'd0, got);
		d = rand_bits(64) | 64'd1;
		do_write(16'h4008, d);
		do_write(16'h0004, d);
		do_read(MTIMECMP_OFS, got);
		check_val("rdata mtimecmp", CMP_MAX, got);
		do_read(MSIP_OFS, got);
		check_val("rdata msip", 64'd0, got);

		// second write knocks while the first response is held back
		d = rand_bits(64);
		drive_write(MTIMECMP_OFS, d);
		finish_write();
		drive_write(MTIMECMP_OFS, ~d);
		n = int'(rand_bits(3)) + 2;
		repeat (n) begin
			@(negedge clk);
			check_val("awready", 64'd0, 64'(awready));
			check_val("bvalid", 64'd1, 64'(bvalid));
		end
		take_bresp();
		finish_write();
		take_bresp();

		// same for reads, rdata must not move
		drive_read(MTIMECMP_OFS);
		finish_read(t0);
		drive_read(MSIP_OFS);
		n = int'(rand_bits(3)) + 2;
		repeat (n) begin
			@(negedge clk);
			check_val("arready", 64'd0, 64'(arready));
			check_val("rvalid", 64'd1, 64'(rvalid));
			check_val("rdata", ~d, rdata);
		end
		take_rresp();
		finish_read(got);
		take_rresp();
		check_val("rdata mtimecmp", ~d, t0); // second write landed last
		check_val("rdata msip", 64'd0, got);

		repeat (2) @(negedge clk);
		$display("errors: %0d value, %0d protocol, %0d timeout", val_err, proto_err, tmo_err);
		if (val_err + proto_err + tmo_err == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule : tb_clint

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int RST_CYCLES = 5 // rising edges with reset held
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// release on a falling edge, like every other dut input
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule : tb_clk_gen

`default_nettype wire
